//--- src/lsuPkg.sv
// Shared widths, index types and packet structs of the load-store unit.
// Every LSU module takes what it needs from here by wildcard import;
// port lists use scoped names. Also holds the small ring-index helpers
// that both queues use for their age-ordered searches.
`default_nettype none

package lsuPkg;

	localparam int LSQ_INDEX_BITS = 3; // queues hold up to 8 entries

	typedef logic [LSQ_INDEX_BITS-1:0] lsqIdx_t; // queue entry index
	typedef logic [LSQ_INDEX_BITS:0]   lsqCount_t; // occupancy, 0..8
	typedef logic [31:0]               addr_t; // byte address, low 2 bits ignored
	typedef logic [31:0]               dataWord_t;

	typedef struct packed {
		logic valid;
		logic isLoad;
	} lsqPkt_t; // dispatch

	typedef struct packed {
		logic      valid;
		logic      isLoad;
		lsqIdx_t   lsqId; // LQ or SQ entry, by isLoad
		addr_t     addr;
		dataWord_t stData; // stores only
	} memPkt_t; // from address generation

	typedef struct packed {
		logic      valid;
		lsqIdx_t   lqId;
		dataWord_t data;
	} wbPkt_t; // load writeback

	typedef struct packed {
		logic    valid;
		lsqIdx_t lqId; // oldest offending load
	} ldVioPkt_t;

	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		addr_t     adr;
		dataWord_t datW;
	} wbReq_t; // wishbone master side

	typedef struct packed {
		logic      ack;
		dataWord_t datR;
	} wbRsp_t; // wishbone slave side

	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_LOAD,
		PORT_STORE
	} portState_t;

	// index base+off on a ring of the given depth
	function automatic lsqIdx_t wrapIdx(input lsqIdx_t base, input int off, input int depth);
		return lsqIdx_t'((int'(base) + off) % depth);
	endfunction

	// entries from 'from' up to, not including, 'to'
	function automatic int ringDist(input lsqIdx_t from, input lsqIdx_t to, input int depth);
		return (int'(to) + depth - int'(from)) % depth;
	endfunction

	function automatic logic wordMatch(input addr_t a, input addr_t b);
		return a[31:2] == b[31:2]; // full-word accesses only
	endfunction

endpackage

`default_nettype wire

//--- src/queuePointers.sv
// Head, tail and occupancy of one circular queue.
// Instantiated once for the load queue and once for the store queue.
// Push and pop may arrive in the same cycle; the caller never pushes
// into a full queue nor pops an empty one.
`default_nettype none

module queuePointers #(
	parameter int depth = 8
) (
	input  logic              clk,
	input  logic              rstN_i,
	input  logic              push_i, // allocate at tail
	input  logic              pop_i, // free head entry
	output lsuPkg::lsqIdx_t   head_o,
	output lsuPkg::lsqIdx_t   tail_o,
	output lsuPkg::lsqCount_t count_o
);
	import lsuPkg::*;

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			head_o  <= '0;
			tail_o  <= '0;
			count_o <= '0; // empty after reset
		end else begin
			if (push_i) begin
				tail_o <= wrapIdx(tail_o, 1, depth); // wraps at depth, not at 8
			end
			if (pop_i) begin
				head_o <= wrapIdx(head_o, 1, depth);
			end
			case ({push_i, pop_i})
				2'b10:   count_o <= count_o + 1'b1;
				2'b01:   count_o <= count_o - 1'b1;
				default: count_o <= count_o; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/storeQueue.sv
// Store queue entries: word address, data and an address-known bit each.
// A load packet searches the stores older than it for the youngest
// word match and forwards that store's data combinationally.
// Committed stores stay here, still searchable, until the memory port
// has written them; drainReq_o asks for the head to be written.
`default_nettype none

module storeQueue #(
	parameter int sqDepth = 8
) (
	input  logic              clk,
	input  logic              rstN_i,
	input  lsuPkg::lsqIdx_t   allocIdx_i, // SQ tail on dispatch
	input  lsuPkg::lsqIdx_t   head_i,
	input  lsuPkg::lsqCount_t count_i,
	input  logic              alloc_i,
	input  lsuPkg::memPkt_t   memPkt_i,
	input  lsuPkg::lsqIdx_t   ldSnap_i, // SQ tail seen by the searching load
	input  logic              commit_i,
	output logic              fwdHit_o,
	output lsuPkg::dataWord_t fwdData_o,
	output logic              drainReq_o,
	output lsuPkg::addr_t     drainAddr_o,
	output lsuPkg::dataWord_t drainData_o
);
	import lsuPkg::*;

	addr_t            addrMem [sqDepth];
	dataWord_t        dataMem [sqDepth];
	logic [sqDepth-1:0] addrValid; // address delivered by agen
	lsqIdx_t          commitPtr; // first store not yet committed
	logic             allCommitted; // commitPtr lapped onto head
	logic             fwdMatch;
	lsqIdx_t          fwdSel;
	lsqIdx_t          commitNext;

	assign commitNext = wrapIdx(commitPtr, 1, sqDepth);

	// payload, written by store packets
	always_ff @(posedge clk) begin
		if (memPkt_i.valid && !memPkt_i.isLoad) begin
			addrMem[memPkt_i.lsqId] <= memPkt_i.addr;
			dataMem[memPkt_i.lsqId] <= memPkt_i.stData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			addrValid <= '0;
		end else begin
			if (memPkt_i.valid && !memPkt_i.isLoad) begin
				addrValid[memPkt_i.lsqId] <= 1'b1;
			end
			if (alloc_i) begin
				addrValid[allocIdx_i] <= 1'b0; // fresh store, address unknown
			end
		end
	end

	// age-masked search, later offsets are younger and win
	always_comb begin
		int      span;
		lsqIdx_t idx;
		span     = ringDist(head_i, ldSnap_i, sqDepth);
		fwdMatch = 1'b0;
		fwdSel   = head_i;
		for (int k = 0; k < sqDepth; k++) begin
			idx = wrapIdx(head_i, k, sqDepth);
			if (k < span && k < int'(count_i) && addrValid[idx] &&
					wordMatch(addrMem[idx], memPkt_i.addr)) begin
				fwdMatch = 1'b1;
				fwdSel   = idx;
			end
		end
	end

	assign fwdHit_o  = memPkt_i.valid && memPkt_i.isLoad && fwdMatch;
	assign fwdData_o = dataMem[fwdSel];

	// commit pointer runs ahead of head by the committed, undrained stores
	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			commitPtr    <= '0;
			allCommitted <= 1'b0;
		end else begin
			if (commit_i) begin
				commitPtr <= commitNext;
			end
			if (commit_i && commitNext == head_i) begin
				allCommitted <= 1'b1; // every live store committed
			end else if (commitPtr != head_i) begin
				allCommitted <= 1'b0; // head moved on, pointers differ again
			end
		end
	end

	assign drainReq_o  = (count_i != '0) && ((commitPtr != head_i) || allCommitted);
	assign drainAddr_o = addrMem[head_i];
	assign drainData_o = dataMem[head_i];

endmodule

`default_nettype wire

//--- src/loadQueue.sv
// Load queue entries: word address, executed flag and the SQ tail seen
// at dispatch. The snapshot of the issuing load goes to the store queue
// to bound its forwarding search. A store packet checks the executed
// loads younger than the store for a word match; the oldest one is
// reported one cycle later as a load violation.
`default_nettype none

module loadQueue #(
	parameter int lqDepth = 8
) (
	input  logic              clk,
	input  logic              rstN_i,
	input  lsuPkg::lsqIdx_t   allocIdx_i, // LQ entry of the dispatched load
	input  lsuPkg::lsqIdx_t   tail_i, // current LQ tail
	input  logic              alloc_i,
	input  lsuPkg::lsqIdx_t   sqSnap_i, // current SQ tail
	input  lsuPkg::memPkt_t   memPkt_i,
	output lsuPkg::lsqIdx_t   ldSnap_o,
	output lsuPkg::ldVioPkt_t ldVioPacket_o
);
	import lsuPkg::*;

	localparam int SQ_SLOTS = 2 ** LSQ_INDEX_BITS;

	addr_t              ldAddr [lqDepth];
	lsqIdx_t            sqSnapMem [lqDepth]; // per load, SQ tail at dispatch
	lsqIdx_t            stLqSnap [SQ_SLOTS]; // per store, LQ tail at dispatch
	logic [lqDepth-1:0] executed;
	logic               vioMatch;
	lsqIdx_t            vioSel;
	logic               vioValidQ;
	lsqIdx_t            vioIdQ;

	always_ff @(posedge clk) begin
		// slot at SQ tail follows LQ tail, freezes once a store takes it
		stLqSnap[sqSnap_i] <= tail_i;
		if (alloc_i) begin
			sqSnapMem[allocIdx_i] <= sqSnap_i;
		end
		if (memPkt_i.valid && memPkt_i.isLoad) begin
			ldAddr[memPkt_i.lsqId] <= memPkt_i.addr;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			executed  <= '0;
			vioValidQ <= 1'b0;
		end else begin
			if (memPkt_i.valid && memPkt_i.isLoad) begin
				executed[memPkt_i.lsqId] <= 1'b1;
			end
			if (alloc_i) begin
				executed[allocIdx_i] <= 1'b0;
			end
			vioValidQ <= memPkt_i.valid && !memPkt_i.isLoad && vioMatch;
		end
	end

	always_ff @(posedge clk) begin
		vioIdQ <= vioSel; // payload only
	end

	assign ldSnap_o = sqSnapMem[memPkt_i.lsqId];

	// younger loads only, lowest offset is oldest and wins
	always_comb begin
		lsqIdx_t base;
		int      span;
		lsqIdx_t idx;
		base     = stLqSnap[memPkt_i.lsqId];
		span     = ringDist(base, tail_i, lqDepth);
		vioMatch = 1'b0;
		vioSel   = base;
		for (int k = lqDepth - 1; k >= 0; k--) begin
			idx = wrapIdx(base, k, lqDepth);
			if (k < span && executed[idx] && wordMatch(ldAddr[idx], memPkt_i.addr)) begin
				vioMatch = 1'b1;
				vioSel   = idx;
			end
		end
	end

	assign ldVioPacket_o = '{valid: vioValidQ, lqId: vioIdQ};

endmodule

`default_nettype wire

//--- src/memPortFsm.sv
// Memory port of the LSU, a Wishbone classic master.
// One transfer at a time: a load that missed the store queue, or else
// the drain of the oldest committed store. All bus signals are held
// until ack; cyc and stb drop as the FSM returns to idle.
// New address packets are accepted only while idle.
`default_nettype none

module memPortFsm (
	input  logic              clk,
	input  logic              rstN_i,
	input  lsuPkg::memPkt_t   memPkt_i,
	input  logic              fwdHit_i,
	input  logic              drainReq_i,
	input  lsuPkg::addr_t     drainAddr_i,
	input  lsuPkg::dataWord_t drainData_i,
	output lsuPkg::wbReq_t    wbReq_o,
	input  lsuPkg::wbRsp_t    wbRsp_i,
	output logic              drainDone_o, // pops the SQ head
	output logic              memReady_o,
	output logic              loadDone_o,
	output lsuPkg::dataWord_t loadData_o,
	output lsuPkg::lsqIdx_t   loadId_o
);
	import lsuPkg::*;

	portState_t state;
	logic       loadMiss;
	logic       weQ;
	addr_t      adrQ;
	dataWord_t  datWQ;
	lsqIdx_t    loadIdQ;
	logic       loadDoneQ;
	dataWord_t  loadDataQ;

	assign loadMiss = memPkt_i.valid && memPkt_i.isLoad && !fwdHit_i;

	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			state     <= PORT_IDLE;
			loadDoneQ <= 1'b0;
		end else begin
			loadDoneQ <= 1'b0; // single-cycle pulse
			case (state)
				PORT_IDLE: begin
					if (loadMiss) begin
						state <= PORT_LOAD; // loads go ahead of drains
					end else if (drainReq_i) begin
						state <= PORT_STORE;
					end
				end
				PORT_LOAD: begin
					if (wbRsp_i.ack) begin
						state     <= PORT_IDLE;
						loadDoneQ <= 1'b1;
					end
				end
				PORT_STORE: begin
					if (wbRsp_i.ack) begin
						state <= PORT_IDLE;
					end
				end
				default: state <= PORT_IDLE;
			endcase
		end
	end

	// request payload, captured on leaving idle
	always_ff @(posedge clk) begin
		if (state == PORT_IDLE && loadMiss) begin
			weQ     <= 1'b0;
			adrQ    <= {memPkt_i.addr[31:2], 2'b00};
			datWQ   <= '0;
			loadIdQ <= memPkt_i.lsqId;
		end else if (state == PORT_IDLE && drainReq_i) begin
			weQ   <= 1'b1;
			adrQ  <= {drainAddr_i[31:2], 2'b00};
			datWQ <= drainData_i;
		end
		if (state == PORT_LOAD && wbRsp_i.ack) begin
			loadDataQ <= wbRsp_i.datR;
		end
	end

	assign wbReq_o = '{
		cyc:  state != PORT_IDLE,
		stb:  state != PORT_IDLE,
		we:   weQ,
		adr:  adrQ,
		datW: datWQ
	};

	assign memReady_o  = state == PORT_IDLE;
	assign drainDone_o = state == PORT_STORE && wbRsp_i.ack;
	assign loadDone_o  = loadDoneQ;
	assign loadData_o  = loadDataQ;
	assign loadId_o    = loadIdQ;

endmodule

`default_nettype wire

//--- src/lsu.sv
// Top of the single-lane load-store unit.
// Dispatch allocates into the load or store queue and returns the
// entry index; address packets search the queues for forwarding and
// violations; commits free loads and release stores to drain.
// Memory is reached through one Wishbone classic master port.
// lqDepth and sqDepth are set here and passed to the queues.
`default_nettype none

module lsu #(
	parameter int lqDepth = 8,
	parameter int sqDepth = 8
) (
	input  logic              clk,
	input  logic              rstN_i,
	input  lsuPkg::lsqPkt_t   lsqPacket_i,
	output lsuPkg::lsqIdx_t   lsqId_o,
	output lsuPkg::lsqCount_t lqCount_o,
	output lsuPkg::lsqCount_t sqCount_o,
	input  lsuPkg::memPkt_t   memPacket_i,
	output logic              memReady_o,
	input  logic              commitLoad_i,
	input  logic              commitStore_i,
	output lsuPkg::wbPkt_t    wbPacket_o,
	output lsuPkg::ldVioPkt_t ldVioPacket_o,
	output lsuPkg::wbReq_t    wbReq_o,
	input  lsuPkg::wbRsp_t    wbRsp_i
);
	import lsuPkg::*;

	lsqIdx_t   lqTail;
	lsqIdx_t   sqHead;
	lsqIdx_t   sqTail;
	logic      lqPush;
	logic      sqPush;
	logic      drainDone;
	logic      fwdHit;
	dataWord_t fwdData;
	lsqIdx_t   ldSnap;
	logic      drainReq;
	addr_t     drainAddr;
	dataWord_t drainData;
	logic      loadDone;
	dataWord_t loadData;
	lsqIdx_t   loadId;
	logic      fwdValidQ;
	lsqIdx_t   fwdIdQ;
	dataWord_t fwdDataQ;

	assign lqPush  = lsqPacket_i.valid && lsqPacket_i.isLoad;
	assign sqPush  = lsqPacket_i.valid && !lsqPacket_i.isLoad;
	assign lsqId_o = lsqPacket_i.isLoad ? lqTail : sqTail; // tail of chosen queue

	queuePointers #(.depth(lqDepth)) lqPtrs (
		.clk     (clk),
		.rstN_i  (rstN_i),
		.push_i  (lqPush),
		.pop_i   (commitLoad_i), // loads retire in order
		.head_o  (),
		.tail_o  (lqTail),
		.count_o (lqCount_o)
	);

	queuePointers #(.depth(sqDepth)) sqPtrs (
		.clk     (clk),
		.rstN_i  (rstN_i),
		.push_i  (sqPush),
		.pop_i   (drainDone), // stores leave only once written
		.head_o  (sqHead),
		.tail_o  (sqTail),
		.count_o (sqCount_o)
	);

	storeQueue #(.sqDepth(sqDepth)) stq (
		.clk        (clk),
		.rstN_i     (rstN_i),
		.allocIdx_i (sqTail),
		.head_i     (sqHead),
		.count_i    (sqCount_o),
		.alloc_i    (sqPush),
		.memPkt_i   (memPacket_i),
		.ldSnap_i   (ldSnap),
		.commit_i   (commitStore_i),
		.fwdHit_o   (fwdHit),
		.fwdData_o  (fwdData),
		.drainReq_o (drainReq),
		.drainAddr_o(drainAddr),
		.drainData_o(drainData)
	);

	loadQueue #(.lqDepth(lqDepth)) ldq (
		.clk          (clk),
		.rstN_i       (rstN_i),
		.allocIdx_i   (lqTail),
		.tail_i       (lqTail),
		.alloc_i      (lqPush),
		.sqSnap_i     (sqTail),
		.memPkt_i     (memPacket_i),
		.ldSnap_o     (ldSnap),
		.ldVioPacket_o(ldVioPacket_o)
	);

	memPortFsm port (
		.clk         (clk),
		.rstN_i      (rstN_i),
		.memPkt_i    (memPacket_i),
		.fwdHit_i    (fwdHit),
		.drainReq_i  (drainReq),
		.drainAddr_i (drainAddr),
		.drainData_i (drainData),
		.wbReq_o     (wbReq_o),
		.wbRsp_i     (wbRsp_i),
		.drainDone_o (drainDone),
		.memReady_o  (memReady_o),
		.loadDone_o  (loadDone),
		.loadData_o  (loadData),
		.loadId_o    (loadId)
	);

	// forwarded load writes back one cycle after its packet
	always_ff @(posedge clk) begin
		if (!rstN_i) begin
			fwdValidQ <= 1'b0;
		end else begin
			fwdValidQ <= fwdHit;
		end
	end

	always_ff @(posedge clk) begin
		fwdIdQ   <= memPacket_i.lsqId;
		fwdDataQ <= fwdData;
	end

	// port is busy during a miss, so the two sources never overlap
	always_comb begin
		if (fwdValidQ) begin
			wbPacket_o = '{valid: 1'b1, lqId: fwdIdQ, data: fwdDataQ};
		end else begin
			wbPacket_o = '{valid: loadDone, lqId: loadId, data: loadData};
		end
	end

endmodule

`default_nettype wire

//--- testbench/lsu_asserts.sv
// Concurrent checks on the LSU, bound into every lsu instance.
// Covers the Wishbone master protocol, queue bounds and the
// output state right after reset.
`default_nettype none

module lsuAsserts #(
	parameter int lqDepth = 8,
	parameter int sqDepth = 8
) (
	input wire logic              clk,
	input wire logic              rstN_i,
	input wire lsuPkg::wbReq_t    wbReq_i,
	input wire lsuPkg::wbRsp_t    wbRsp_i,
	input wire lsuPkg::lsqCount_t lqCount_i,
	input wire lsuPkg::lsqCount_t sqCount_i,
	input wire lsuPkg::wbPkt_t    wbPacket_i,
	input wire lsuPkg::ldVioPkt_t ldVioPacket_i
);
	timeunit 1ns;
	timeprecision 100ps;

	stbNeedsCyc: assert property (@(posedge clk) disable iff (!rstN_i)
		wbReq_i.stb |-> wbReq_i.cyc)
		else $error("stb high without cyc");

	// master holds the request until the slave answers
	reqStable: assert property (@(posedge clk) disable iff (!rstN_i)
		wbReq_i.stb && !wbRsp_i.ack |=>
		$stable(wbReq_i.adr) && $stable(wbReq_i.we) && $stable(wbReq_i.datW))
		else $error("bus request changed while waiting for ack");

	lqBound: assert property (@(posedge clk) disable iff (!rstN_i)
		int'(lqCount_i) <= lqDepth)
		else $error("load queue count above depth");

	sqBound: assert property (@(posedge clk) disable iff (!rstN_i)
		int'(sqCount_i) <= sqDepth)
		else $error("store queue count above depth");

	quietAfterReset: assert property (@(posedge clk)
		$rose(rstN_i) |-> !wbPacket_i.valid && !ldVioPacket_i.valid)
		else $error("packet valid right after reset");

endmodule

bind lsu lsuAsserts #(.lqDepth(lqDepth), .sqDepth(sqDepth)) asserts (
	.clk          (clk),
	.rstN_i       (rstN_i),
	.wbReq_i      (wbReq_o),
	.wbRsp_i      (wbRsp_i),
	.lqCount_i    (lqCount_o),
	.sqCount_i    (sqCount_o),
	.wbPacket_i   (wbPacket_o),
	.ldVioPacket_i(ldVioPacket_o)
);

`default_nettype wire

//--- testbench/lsuTb.sv
// Testbench of the load-store unit. Reads operations and expected results
// from testbench/lsu_cases.txt, drives the DUT through them and answers
// its Wishbone master with a memory model that inserts random wait states.
// Run from the project root so the case file is found.
`default_nettype none

module lsuTb;
	timeunit 1ns;
	timeprecision 100ps;
	import lsuPkg::*;

	logic      clk;
	logic      rstN_i;
	lsqPkt_t   lsqPacket_i;
	lsqIdx_t   lsqId_o;
	lsqCount_t lqCount_o;
	lsqCount_t sqCount_o;
	memPkt_t   memPacket_i;
	logic      memReady_o;
	logic      commitLoad_i;
	logic      commitStore_i;
	wbPkt_t    wbPacket_o;
	ldVioPkt_t ldVioPacket_o;
	wbReq_t    wbReq_o;
	wbRsp_t    wbRsp_i = '0; // no ack before the first clock edge

	dataWord_t memModel [addr_t]; // written words, keyed by word address
	logic      started; // slave has seen the current request
	int        waitLeft;
	int        errorCount;
	int        commitsIssued; // store commits driven so far
	int        drainsSeen; // store writes acked on the bus
	int        caseCount;
	int        caseOp [$];
	int        caseId [$];
	dataWord_t caseAddr [$];
	dataWord_t caseData [$];
	dataWord_t caseExp [$];

	lsu #(.lqDepth(8), .sqDepth(8)) DUT (
		.clk          (clk),
		.rstN_i       (rstN_i),
		.lsqPacket_i  (lsqPacket_i),
		.lsqId_o      (lsqId_o),
		.lqCount_o    (lqCount_o),
		.sqCount_o    (sqCount_o),
		.memPacket_i  (memPacket_i),
		.memReady_o   (memReady_o),
		.commitLoad_i (commitLoad_i),
		.commitStore_i(commitStore_i),
		.wbPacket_o   (wbPacket_o),
		.ldVioPacket_o(ldVioPacket_o),
		.wbReq_o      (wbReq_o),
		.wbRsp_i      (wbRsp_i)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	task automatic failRun();
		errorCount++;
		$display("TEST FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkData(input string name, input dataWord_t got, input dataWord_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkLqId(input string name, input lsqIdx_t got, input lsqIdx_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkCount(input string name, input lsqCount_t got, input lsqCount_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			failRun();
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			failRun();
		end
	endtask

	// unwritten words read back as word address xor a fixed pattern
	function automatic dataWord_t readWord(input addr_t adr);
		addr_t key;
		key = {2'b00, adr[31:2]};
		if (memModel.exists(key)) begin
			return memModel[key];
		end
		return key ^ 32'hA5A5_0000;
	endfunction

	// wishbone slave, 0 to 3 wait states per transfer
	always @(posedge clk) begin
		int w;
		if (!rstN_i) begin
			wbRsp_i  <= '0;
			started  <= 1'b0;
			waitLeft <= 0;
		end else begin
			wbRsp_i.ack <= 1'b0;
			if (wbReq_o.cyc && wbReq_o.stb && !wbRsp_i.ack) begin
				if (!started) begin
					w = int'($urandom % 4);
				end else begin
					w = waitLeft;
				end
				if (w == 0) begin
					wbRsp_i.ack  <= 1'b1;
					wbRsp_i.datR <= readWord(wbReq_o.adr);
					started      <= 1'b0;
					if (wbReq_o.we) begin
						memModel[{2'b00, wbReq_o.adr[31:2]}] = wbReq_o.datW;
					end
				end else begin
					started  <= 1'b1;
					waitLeft <= w - 1;
				end
			end
		end
	end

	// counts acked store writes, so packets wait out pending drains
	always @(negedge clk) begin
		if (rstN_i && wbReq_o.cyc && wbReq_o.stb && wbReq_o.we && wbRsp_i.ack) begin
			drainsSeen++;
		end
	end

	initial begin
		wait (caseCount > 0);
		repeat (caseCount * 40) @(posedge clk);
		$display("timeout, the DUT stopped responding");
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic readCases();
		int    fd;
		int    n;
		int    op;
		int    id;
		addr_t a;
		dataWord_t d;
		dataWord_t e;
		string line;
		fd = $fopen("testbench/lsu_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/lsu_cases.txt");
			failRun();
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#") begin
				n = $sscanf(line, "%h %h %h %h %h", op, id, a, d, e);
				if (n == 5) begin
					caseOp.push_back(op);
					caseId.push_back(id);
					caseAddr.push_back(a);
					caseData.push_back(d);
					caseExp.push_back(e);
				end
			end
		end
		$fclose(fd);
		caseCount = caseOp.size();
		if (caseCount == 0) begin
			$display("no operations found in testbench/lsu_cases.txt");
			failRun();
		end
	endtask

	// port idle and every store commit already seen by the DUT has drained
	task automatic waitPortFree();
		@(negedge clk);
		while (!(memReady_o && commitsIssued - int'(commitStore_i) == drainsSeen)) begin
			@(negedge clk);
		end
	endtask

	task automatic dispatch(input logic isLoad, input lsqIdx_t expId);
		@(posedge clk);
		lsqPacket_i <= '{valid: 1'b1, isLoad: isLoad};
		@(negedge clk);
		checkLqId("lsqId_o", lsqId_o, expId);
		@(posedge clk);
		lsqPacket_i <= '0;
	endtask

	task automatic issueLoad(input lsqIdx_t id, input addr_t a, input dataWord_t exp);
		waitPortFree();
		@(posedge clk);
		memPacket_i <= '{valid: 1'b1, isLoad: 1'b1, lsqId: id, addr: a, stData: '0};
		@(posedge clk);
		memPacket_i <= '0;
		@(negedge clk);
		while (!wbPacket_o.valid) begin
			checkBit("memReady_o", memReady_o, 1'b0); // port busy until the writeback
			@(negedge clk);
		end
		checkLqId("wbPacket_o.lqId", wbPacket_o.lqId, id);
		checkData("wbPacket_o.data", wbPacket_o.data, exp);
	endtask

	task automatic issueStore(input lsqIdx_t id, input addr_t a, input dataWord_t d,
			input dataWord_t expVio);
		waitPortFree();
		@(posedge clk);
		memPacket_i <= '{valid: 1'b1, isLoad: 1'b0, lsqId: id, addr: a, stData: d};
		@(posedge clk);
		memPacket_i <= '0;
		@(negedge clk);
		checkBit("ldVioPacket_o.valid", ldVioPacket_o.valid, expVio < 8);
		if (expVio < 8) begin
			checkLqId("ldVioPacket_o.lqId", ldVioPacket_o.lqId, lsqIdx_t'(expVio));
		end
	endtask

	// a store commit drops again one cycle later while the next operation starts
	task automatic pulseCommit(input logic isLoad);
		@(posedge clk);
		while (commitStore_i) begin
			@(posedge clk); // previous store commit still high
		end
		if (isLoad) begin
			commitLoad_i <= 1'b1;
			@(posedge clk);
			commitLoad_i <= 1'b0;
		end else begin
			commitStore_i <= 1'b1;
			commitsIssued++;
			fork
				begin
					@(posedge clk);
					commitStore_i <= 1'b0;
				end
			join_none
		end
	endtask

	initial begin
		errorCount    = 0;
		commitsIssued = 0;
		drainsSeen    = 0;
		caseCount     = 0;
		rstN_i        = 1'b0;
		lsqPacket_i   = '0;
		memPacket_i   = '0;
		commitLoad_i  = 1'b0;
		commitStore_i = 1'b0;
		void'($urandom(27789));
		readCases();
		repeat (3) @(posedge clk);
		rstN_i <= 1'b1;
		@(negedge clk);
		checkCount("lqCount_o", lqCount_o, '0);
		checkCount("sqCount_o", sqCount_o, '0);
		checkBit("memReady_o", memReady_o, 1'b1);
		for (int i = 0; i < caseCount; i++) begin
			case (caseOp[i])
				0: repeat (caseAddr[i]) @(posedge clk); // idle cycles
				1: dispatch(1'b1, lsqIdx_t'(caseExp[i]));
				2: dispatch(1'b0, lsqIdx_t'(caseExp[i]));
				3: issueLoad(lsqIdx_t'(caseId[i]), caseAddr[i], caseExp[i]);
				4: issueStore(lsqIdx_t'(caseId[i]), caseAddr[i], caseData[i], caseExp[i]);
				5: pulseCommit(1'b1);
				6: pulseCommit(1'b0);
				7: begin
					@(negedge clk);
					checkCount("lqCount_o", lqCount_o, lsqCount_t'(caseAddr[i]));
					checkCount("sqCount_o", sqCount_o, lsqCount_t'(caseData[i]));
				end
				8: begin
					@(negedge clk);
					while (sqCount_o != '0) begin
						@(negedge clk);
					end
				end
				default: begin
					$display("unknown operation %0d in case file line %0d", caseOp[i], i);
					failRun();
				end
			endcase
		end
		repeat (2) @(posedge clk);
		if (errorCount == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
src/lsuPkg.sv
src/queuePointers.sv
src/storeQueue.sv
src/loadQueue.sv
src/memPortFsm.sv
src/lsu.sv
testbench/lsu_asserts.sv
testbench/lsuTb.sv

//--- run.sh
#!/bin/sh
# Builds the LSU testbench with Verilator, runs it, and looks for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module lsuTb -f filelist.f -o lsuSim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/lsuSim > sim.log 2>&1
cat sim.log
grep -q "^TEST PASSED$" sim.log && exit 0 || exit 1

//--- testbench/lsu_cases.txt
# columns: op id addr data expected, all hex
# op 0 idle addr cycles, 1/2 dispatch load/store, 3 load, 4 store, 5/6 commit, 7 counts, 8 drain
1 0 00000000 00000000 00000000
3 0 00000100 00000000 A5A50040
5 0 00000000 00000000 00000000
2 0 00000000 00000000 00000000
4 0 00000200 11111111 00000008
2 0 00000000 00000000 00000001
4 1 00000200 22222222 00000008
1 0 00000000 00000000 00000001
3 1 00000202 00000000 22222222
7 0 00000001 00000002 00000000
5 0 00000000 00000000 00000000
2 0 00000000 00000000 00000002
1 0 00000000 00000000 00000002
1 0 00000000 00000000 00000003
3 2 00000300 00000000 A5A500C0
3 3 00000300 00000000 A5A500C0
4 2 00000300 33333333 00000002
5 0 00000000 00000000 00000000
5 0 00000000 00000000 00000000
6 0 00000000 00000000 00000000
6 0 00000000 00000000 00000000
6 0 00000000 00000000 00000000
8 0 00000000 00000000 00000000
7 0 00000000 00000000 00000000
1 0 00000000 00000000 00000004
3 4 00000200 00000000 22222222
1 0 00000000 00000000 00000005
3 5 00000300 00000000 33333333
5 0 00000000 00000000 00000000
5 0 00000000 00000000 00000000
0 0 00000002 00000000 00000000
2 0 00000000 00000000 00000003
4 3 00000400 44444444 00000008
1 0 00000000 00000000 00000006
6 0 00000000 00000000 00000000
3 6 00000400 00000000 44444444
1 0 00000000 00000000 00000007
1 0 00000000 00000000 00000000
3 7 00000500 00000000 A5A50140
3 0 00000504 00000000 A5A50141
5 0 00000000 00000000 00000000
5 0 00000000 00000000 00000000
5 0 00000000 00000000 00000000
8 0 00000000 00000000 00000000
7 0 00000000 00000000 00000000
